/* rtl/bridge_macros.svh */
`ifndef BRIDGE_MACROS_SVH
`define BRIDGE_MACROS_SVH

// address bus width
`define BRIDGE_ADDR_W 32

// data word and system index width
`define BRIDGE_DATA_W 32

// index flag bit, left out of the magnitude order
`define BRIDGE_INDEX_ACTIVE_BIT 31

// thread header skipped at launch, in words
`define BRIDGE_THREAD_HEADER_SPACE 16

// core state code width
`define BRIDGE_STATE_W 6

`endif

/* rtl/bridge_state_pkg.sv */
`include "bridge_macros.svh"

package bridge_state_pkg;

  // core FSM states seen by the bridge
  typedef enum logic [`BRIDGE_STATE_W-1:0] {
    wait_for_start,
    start_read_cmd,
    start_read_cmd_p,
    read_mem_size_1,
    read_cond,
    read_cond_p,
    read_src1,
    read_src1_p,
    read_src0,
    read_src0_p,
    read_dst,
    read_dst_p,
    write_reg_ip,
    write_dst,
    write_dst_p,
    write_src1,
    write_src0,
    write_cond,
    alu_begin,
    finish_begin,
    finish_end,
    other
  } core_state_e;

  // state groups the token logic cares about
  typedef struct packed {
    logic is_read;
    logic is_write;
    logic is_launch;
    logic is_finish;
  } state_class_t;

endpackage

/* rtl/bridge_msg_pkg.sv */
`include "bridge_macros.svh"

package bridge_msg_pkg;

  // inter-core messages, one bus word each
  typedef enum logic [`BRIDGE_DATA_W-1:0] {
    msg_none      = 0,
    msg_reset     = 1,
    msg_start     = 2,
    msg_end       = 3,
    msg_fork_thrd = 4,
    msg_stop_thrd = 5,
    msg_fork_done = 6,
    msg_stop_done = 7
  } cpu_msg_e;

  // rank of an offered index against our own
  typedef enum logic [1:0] {
    rel_none  = 2'b00,
    rel_below = 2'b01,
    rel_above = 2'b10,
    rel_same  = 2'b11
  } ind_rel_e;

  // thread base addresses set up at launch
  typedef struct packed {
    // code start, past the header
    logic [`BRIDGE_ADDR_W-1:0] base_addr;
    // data start, falls back to code start
    logic [`BRIDGE_ADDR_W-1:0] base_addr_data;
  } launch_addr_t;

endpackage

/* rtl/state_class_decoder.sv */
`timescale 1ns/10ps

module state_class_decoder (
  input  bridge_state_pkg::core_state_e  state,
  input  logic                           read_q,
  input  logic                           write_q,
  input  logic                           disp_online,
  output bridge_state_pkg::state_class_t state_class,
  output logic                           ext_read_q,
  output logic                           ext_write_q
);
  import bridge_state_pkg::*;

  // group core states into classes
  always_comb begin
    state_class = '0;
    case (state)
      start_read_cmd, start_read_cmd_p, read_mem_size_1,
      read_cond, read_cond_p, read_src1, read_src1_p,
      read_src0, read_src0_p, read_dst, read_dst_p: begin
        state_class.is_read = 1'b1;
      end
      write_reg_ip, write_dst, write_dst_p,
      write_src1, write_src0, write_cond: begin
        state_class.is_write = 1'b1;
      end
      wait_for_start: begin
        state_class.is_launch = 1'b1;
      end
      finish_begin: begin
        state_class.is_finish = 1'b1;
      end
      default: begin
      end
    endcase
  end

  // core requests reach the outside bus only while we hold the token
  assign ext_read_q  = (disp_online && state_class.is_read) ? read_q : 1'b0;
  assign ext_write_q = (disp_online && state_class.is_write) ? write_q : 1'b0;

  // one outside access at a time
  a_rw_exclusive: assert final (!(ext_read_q && ext_write_q))
    else $error("outside read and write requested together");

endmodule

/* rtl/reset_sequencer.sv */
`timescale 1ns/10ps
`include "bridge_macros.svh"

module reset_sequencer (
  input  logic                          clk,
  input  logic                          ext_rst_b,
  input  bridge_state_pkg::core_state_e state,
  input  logic [`BRIDGE_DATA_W-1:0]     ext_cpu_index,
  input  logic                          restart,
  output logic                          ready,
  output logic [`BRIDGE_DATA_W-1:0]     cpu_index,
  output bridge_msg_pkg::cpu_msg_e      seq_msg,
  output logic                          rst,
  output logic                          ext_rst_e,
  output logic                          bus_busy_out
);
  import bridge_state_pkg::*;
  import bridge_msg_pkg::*;

  // reset and join steps
  typedef enum logic [2:0] {
    seq_step_1,
    seq_step_2,
    seq_step_3,
    seq_step_4,
    seq_step_5,
    seq_done
  } seq_step_e;

  seq_step_e seq_step;

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      seq_step  <= seq_step_1;
      cpu_index <= '0;
      rst       <= 1'b0;
      ext_rst_e <= 1'b0;
    end else if (restart) begin
      // thread finished, join again
      seq_step <= seq_step_1;
    end else begin
      // core reset and join strobe are single pulses
      rst       <= 1'b0;
      ext_rst_e <= 1'b0;
      case (seq_step)
        seq_step_1: begin
          seq_step <= seq_step_2;
        end
        seq_step_2: begin
          // after a finish the index is kept, no capture
          seq_step <= (state == finish_end) ? seq_step_4 : seq_step_3;
        end
        seq_step_3: begin
          // system index as handed out by the machine
          cpu_index <= ext_cpu_index;
          seq_step  <= seq_step_4;
        end
        seq_step_4: begin
          rst       <= 1'b1;
          // no join strobe when coming back from a finished thread
          ext_rst_e <= (state != finish_end);
          seq_step  <= seq_step_5;
        end
        seq_step_5: begin
          seq_step <= seq_done;
        end
        default: begin
          seq_step <= seq_done;
        end
      endcase
    end
  end

  assign ready = (seq_step == seq_done);

  // reset message leaves during the capture step
  assign seq_msg = (seq_step == seq_step_3) ? msg_reset : msg_none;

  // outside bus is held while the core restarts
  assign bus_busy_out = rst;

  a_rst_single_cycle: assert property (@(posedge clk) disable iff (ext_rst_b)
    rst |=> !rst)
    else $error("core reset held longer than one cycle");

endmodule

/* rtl/token_controller.sv */
`timescale 1ns/10ps
`include "bridge_macros.svh"

module token_controller (
  input  logic                           clk,
  input  logic                           ext_rst_b,
  input  logic                           ready,
  input  bridge_state_pkg::state_class_t state_class,
  input  bridge_state_pkg::core_state_e  state,
  input  logic                           read_q,
  input  logic                           write_q,
  input  logic                           bus_busy_in,
  input  logic                           ext_next_cpu_q,
  input  logic [`BRIDGE_DATA_W-1:0]      ext_cpu_index,
  input  logic [`BRIDGE_DATA_W-1:0]      cpu_index,
  input  logic [`BRIDGE_ADDR_W-1:0]      addr_in,
  input  logic [`BRIDGE_DATA_W-1:0]      data_in,
  input  bridge_msg_pkg::cpu_msg_e       ext_cpu_msg_in,
  output logic                           disp_online,
  output logic                           ext_next_cpu_e,
  output logic                           ext_dispatcher_q,
  output logic                           next_state,
  output bridge_msg_pkg::launch_addr_t   launch,
  output bridge_msg_pkg::cpu_msg_e       ctl_msg,
  output logic                           restart
);
  import bridge_state_pkg::*;
  import bridge_msg_pkg::*;

  logic                      token_match;
  logic                      active;
  logic                      launch_go;
  logic                      finish_go;
  logic                      rw_release;
  logic                      done_release;
  logic [`BRIDGE_ADDR_W-1:0] data_base;

  // dispatcher token carries our index
  assign token_match = ext_next_cpu_q && (ext_cpu_index == cpu_index);

  // token logic runs only when joined and the bus is free
  assign active    = ready && !bus_busy_in;
  assign launch_go = active && token_match && state_class.is_launch;
  assign finish_go = active && token_match && state_class.is_finish;

  // token goes back once the core has issued its request
  assign rw_release = disp_online && (read_q || write_q);

  // or once a fork or stop has been acknowledged
  assign done_release = (state == alu_begin) &&
                        ((ext_cpu_msg_in == msg_fork_done) ||
                         (ext_cpu_msg_in == msg_stop_done));

  // zero data pointer means data follows the code
  assign data_base = (data_in == '0) ? addr_in : data_in;

  always_comb begin
    ctl_msg = msg_none;
    if (launch_go) begin
      ctl_msg = msg_start;
    end else if (finish_go) begin
      ctl_msg = msg_end;
    end
  end

  // finished thread, sequencer joins again
  assign restart = active && !token_match && (state == finish_end);

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      disp_online      <= 1'b0;
      ext_next_cpu_e   <= 1'b0;
      ext_dispatcher_q <= 1'b0;
      next_state       <= 1'b0;
    end else if (!ready) begin
      // not joined yet, hand any token straight back
      disp_online      <= 1'b0;
      ext_dispatcher_q <= 1'b0;
      next_state       <= 1'b0;
      ext_next_cpu_e   <= token_match;
    end else begin
      next_state <= 1'b0;
      // busy bus freezes the token state
      if (!bus_busy_in) begin
        ext_dispatcher_q <= state_class.is_read || state_class.is_write;
        if (ext_next_cpu_e) begin
          disp_online <= 1'b0;
        end else if (token_match) begin
          disp_online <= 1'b1;
        end
        ext_next_cpu_e <= rw_release || done_release || launch_go || finish_go;
        if (launch_go || finish_go) begin
          next_state <= 1'b1;
        end
      end
    end
  end

  // thread base addresses, taken on launch only
  always_ff @(posedge clk) begin
    if (launch_go) begin
      launch.base_addr      <= addr_in + `BRIDGE_ADDR_W'(`BRIDGE_THREAD_HEADER_SPACE);
      launch.base_addr_data <= data_base + `BRIDGE_ADDR_W'(`BRIDGE_THREAD_HEADER_SPACE);
    end
  end

  // core only advances while the token is being passed on
  a_next_state_release: assert property (@(posedge clk) disable iff (ext_rst_b)
    next_state |-> ext_next_cpu_e)
    else $error("next_state without token release");

endmodule

/* rtl/message_router.sv */
`timescale 1ns/10ps

module message_router (
  input  logic                     clk,
  input  logic                     ext_rst_b,
  input  bridge_msg_pkg::cpu_msg_e seq_msg,
  input  bridge_msg_pkg::cpu_msg_e ctl_msg,
  input  bridge_msg_pkg::cpu_msg_e int_cpu_msg_in,
  input  bridge_msg_pkg::cpu_msg_e ext_cpu_msg_in,
  output bridge_msg_pkg::cpu_msg_e ext_cpu_msg,
  output bridge_msg_pkg::cpu_msg_e int_cpu_msg_out
);
  import bridge_msg_pkg::*;

  cpu_msg_e msg_q;

  // sequencer message wins over the controller one
  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      msg_q <= msg_none;
    end else begin
      msg_q <= (seq_msg != msg_none) ? seq_msg : ctl_msg;
    end
  end

  // fork and stop from our core go out in the same cycle
  assign ext_cpu_msg = ((int_cpu_msg_in == msg_fork_thrd) ||
                        (int_cpu_msg_in == msg_stop_thrd)) ? int_cpu_msg_in : msg_q;

  // only completions are passed in to the core
  assign int_cpu_msg_out = ((ext_cpu_msg_in == msg_fork_done) ||
                            (ext_cpu_msg_in == msg_stop_done)) ? ext_cpu_msg_in : msg_none;

endmodule

/* rtl/index_comparator.sv */
`timescale 1ns/10ps
`include "bridge_macros.svh"

module index_comparator (
  input  logic                      clk,
  input  logic                      ext_rst_b,
  input  logic                      rst,
  input  logic                      ext_next_cpu_q,
  input  logic                      ext_next_cpu_e,
  input  logic [`BRIDGE_DATA_W-1:0] ext_cpu_index,
  input  logic [`BRIDGE_DATA_W-1:0] cpu_index,
  output bridge_msg_pkg::ind_rel_e  ind_rel
);
  import bridge_msg_pkg::*;

  logic [`BRIDGE_INDEX_ACTIVE_BIT-1:0] ext_mag;
  logic [`BRIDGE_INDEX_ACTIVE_BIT-1:0] own_mag;

  // magnitudes without the active flag
  assign ext_mag = ext_cpu_index[`BRIDGE_INDEX_ACTIVE_BIT-1:0];
  assign own_mag = cpu_index[`BRIDGE_INDEX_ACTIVE_BIT-1:0];

  always_ff @(posedge clk) begin
    if (ext_rst_b || rst) begin
      ind_rel <= rel_none;
    end else if (ext_next_cpu_q) begin
      if (ext_mag < own_mag) begin
        ind_rel <= rel_below;
      end else if (ext_mag > own_mag) begin
        ind_rel <= rel_above;
      end else if (ext_cpu_index == cpu_index) begin
        ind_rel <= rel_same;
      end
      // same magnitude, other flag: keep last relation
    end else if (ext_next_cpu_e) begin
      // token passed on
      ind_rel <= rel_none;
    end
  end

endmodule

/* rtl/bridge_to_outside.sv */
`timescale 1ns/10ps
`include "bridge_macros.svh"

module bridge_to_outside (
  input  logic                          clk,
  input  logic                          ext_rst_b,
  input  bridge_state_pkg::core_state_e state,
  input  logic                          read_q,
  input  logic                          write_q,
  input  logic [`BRIDGE_ADDR_W-1:0]     addr_in,
  input  logic [`BRIDGE_DATA_W-1:0]     data_in,
  input  logic                          bus_busy_in,
  input  logic                          ext_next_cpu_q,
  input  logic [`BRIDGE_DATA_W-1:0]     ext_cpu_index,
  input  bridge_msg_pkg::cpu_msg_e      int_cpu_msg_in,
  input  bridge_msg_pkg::cpu_msg_e      ext_cpu_msg_in,
  output logic [`BRIDGE_ADDR_W-1:0]     base_addr,
  output logic [`BRIDGE_ADDR_W-1:0]     base_addr_data,
  output bridge_msg_pkg::ind_rel_e      ind_rel,
  output logic                          bus_busy_out,
  output logic                          disp_online,
  output logic                          next_state,
  output logic                          rst,
  output logic                          ext_rst_e,
  output logic                          ext_next_cpu_e,
  output logic                          ext_dispatcher_q,
  output bridge_msg_pkg::cpu_msg_e      ext_cpu_msg,
  output bridge_msg_pkg::cpu_msg_e      int_cpu_msg_out,
  output logic                          ext_read_q,
  output logic                          ext_write_q
);
  import bridge_state_pkg::*;
  import bridge_msg_pkg::*;

  logic                      ready;
  logic                      restart;
  logic [`BRIDGE_DATA_W-1:0] cpu_index;
  cpu_msg_e                  seq_msg;
  cpu_msg_e                  ctl_msg;
  state_class_t              state_class;
  launch_addr_t              launch;

  reset_sequencer reset_sequencer_inst (
    .clk, .ext_rst_b, .state, .ext_cpu_index, .restart,
    .ready, .cpu_index, .seq_msg, .rst, .ext_rst_e, .bus_busy_out
  );

  state_class_decoder state_class_decoder_inst (
    .state, .read_q, .write_q, .disp_online,
    .state_class, .ext_read_q, .ext_write_q
  );

  token_controller token_controller_inst (
    .clk, .ext_rst_b, .ready, .state_class, .state, .read_q, .write_q,
    .bus_busy_in, .ext_next_cpu_q, .ext_cpu_index, .cpu_index, .addr_in,
    .data_in, .ext_cpu_msg_in, .disp_online, .ext_next_cpu_e,
    .ext_dispatcher_q, .next_state, .launch, .ctl_msg, .restart
  );

  message_router message_router_inst (
    .clk, .ext_rst_b, .seq_msg, .ctl_msg, .int_cpu_msg_in, .ext_cpu_msg_in,
    .ext_cpu_msg, .int_cpu_msg_out
  );

  index_comparator index_comparator_inst (
    .clk, .ext_rst_b, .rst, .ext_next_cpu_q, .ext_next_cpu_e,
    .ext_cpu_index, .cpu_index, .ind_rel
  );

  // launch addresses out to the core
  assign base_addr      = launch.base_addr;
  assign base_addr_data = launch.base_addr_data;

endmodule

/* test/bridge_tb_tasks.svh */
// value mismatch seen by a check
task automatic note_mismatch(input string what);
  value_errs++;
  $display("ERR %0t: %s", $time, what);
endtask

function automatic bit read_class(input core_state_e st);
  return st inside {start_read_cmd, start_read_cmd_p, read_mem_size_1, read_cond, read_cond_p,
                    read_src1, read_src1_p, read_src0, read_src0_p, read_dst, read_dst_p};
endfunction

function automatic bit write_class(input core_state_e st);
  return st inside {write_reg_ip, write_dst, write_dst_p, write_src1, write_src0, write_cond};
endfunction

// magnitude order without the flag and full match for same
function automatic ind_rel_e expected_rank(input logic [`BRIDGE_DATA_W-1:0] offered,
                                           input logic [`BRIDGE_DATA_W-1:0] own);
  if (offered[`BRIDGE_INDEX_ACTIVE_BIT-1:0] < own[`BRIDGE_INDEX_ACTIVE_BIT-1:0]) return rel_below;
  if (offered[`BRIDGE_INDEX_ACTIVE_BIT-1:0] > own[`BRIDGE_INDEX_ACTIVE_BIT-1:0]) return rel_above;
  return (offered == own) ? rel_same : rel_none;
endfunction

// four reset edges and then the core reset of the join
task automatic apply_reset();
  ext_rst_b <= 1'b1;
  repeat (4) @(posedge clk);
  ext_rst_b <= 1'b0;
  do begin
    @(posedge clk);
  end while (!rst);
  // ready is up after the edge that ends the pulse
  @(posedge clk);
endtask

// one-cycle dispatcher token
task automatic offer_token(input logic [`BRIDGE_DATA_W-1:0] idx, input core_state_e st);
  @(posedge clk);
  ext_next_cpu_q <= 1'b1;
  ext_cpu_index  <= idx;
  state          <= st;
  @(posedge clk);
  ext_next_cpu_q <= 1'b0;
endtask

task automatic wait_offline();
  @(posedge clk);
  while (disp_online || ext_next_cpu_e) @(posedge clk);
endtask

// launch with zero or nonzero data pointer
task automatic run_launch(input bit zero_data);
  addr_in <= $urandom;
  data_in <= zero_data ? '0 : ($urandom | 32'd1);
  offer_token(own_idx, wait_for_start);
  state <= other;
  wait_offline();
endtask

// take the token and hand it back with one request cycle
task automatic gate_request(input core_state_e st, input logic rd, input logic wr);
  offer_token(own_idx, st);
  read_q  <= rd;
  write_q <= wr;
  @(posedge clk);
  read_q  <= 1'b0;
  write_q <= 1'b0;
  wait_offline();
endtask

// requests without the token are all gated off
task automatic idle_requests(input int cycles);
  core_state_e pool [6];
  pool = '{read_src1, read_dst_p, write_dst, write_cond, alu_begin, other};
  repeat (cycles) begin
    @(posedge clk);
    state   <= pool[$urandom_range(5)];
    read_q  <= 1'($urandom_range(1));
    write_q <= 1'($urandom_range(1));
  end
  @(posedge clk);
  read_q  <= 1'b0;
  write_q <= 1'b0;
  state   <= other;
endtask

// every message word both ways plus one outside the set
task automatic sweep_messages();
  for (int i = 0; i < 9; i++) begin
    @(posedge clk);
    int_cpu_msg_in <= (i < 8) ? cpu_msg_e'(i) : cpu_msg_e'($urandom);
    ext_cpu_msg_in <= (i < 8) ? cpu_msg_e'(i) : cpu_msg_e'($urandom);
  end
  @(posedge clk);
  int_cpu_msg_in <= msg_none;
  ext_cpu_msg_in <= msg_none;
endtask

// foreign indices above and below ours with a random flag
task automatic rank_offers(input int rounds);
  logic [`BRIDGE_DATA_W-1:0] offered;
  logic [27:0]               delta;
  repeat (rounds) begin
    delta   = 28'($urandom) | 28'd1;
    offered = ($urandom_range(1) == 1) ? own_idx + delta : own_idx - delta;
    offered[`BRIDGE_INDEX_ACTIVE_BIT] = 1'($urandom_range(1));
    offer_token(offered, other);
    @(posedge clk);
  end
endtask

// matching tokens under a busy bus while offline and then online
task automatic stall_token();
  @(posedge clk);
  bus_busy_in <= 1'b1;
  offer_token(own_idx, wait_for_start);
  state <= other;
  @(posedge clk);
  bus_busy_in <= 1'b0;
  offer_token(own_idx, read_cond);
  // pending read must not release while busy
  bus_busy_in <= 1'b1;
  read_q      <= 1'b1;
  @(posedge clk);
  ext_next_cpu_q <= 1'b1;
  @(posedge clk);
  ext_next_cpu_q <= 1'b0;
  bus_busy_in    <= 1'b0;
  @(posedge clk);
  read_q <= 1'b0;
  wait_offline();
endtask

/* test/tb_bridge_to_outside.sv */
`timescale 1ns/10ps
`include "bridge_macros.svh"

module tb_bridge_to_outside;
  import bridge_state_pkg::*;
  import bridge_msg_pkg::*;

  // limit well above the roughly 150 cycle directed run
  localparam int CYCLE_LIMIT = 2000;
  localparam logic [`BRIDGE_ADDR_W-1:0] HDR = `BRIDGE_THREAD_HEADER_SPACE;

  logic                      clk;
  logic                      ext_rst_b;
  core_state_e               state;
  logic                      read_q;
  logic                      write_q;
  logic [`BRIDGE_ADDR_W-1:0] addr_in;
  logic [`BRIDGE_DATA_W-1:0] data_in;
  logic                      bus_busy_in;
  logic                      ext_next_cpu_q;
  logic [`BRIDGE_DATA_W-1:0] ext_cpu_index;
  cpu_msg_e                  int_cpu_msg_in;
  cpu_msg_e                  ext_cpu_msg_in;
  logic [`BRIDGE_ADDR_W-1:0] base_addr;
  logic [`BRIDGE_ADDR_W-1:0] base_addr_data;
  ind_rel_e                  ind_rel;
  logic                      bus_busy_out;
  logic                      disp_online;
  logic                      next_state;
  logic                      rst;
  logic                      ext_rst_e;
  logic                      ext_next_cpu_e;
  logic                      ext_dispatcher_q;
  cpu_msg_e                  ext_cpu_msg;
  cpu_msg_e                  int_cpu_msg_out;
  logic                      ext_read_q;
  logic                      ext_write_q;

  // index handed to the DUT during the join
  logic [`BRIDGE_DATA_W-1:0] own_idx;
  int                        edge_cnt = 0;
  int                        cycle_cnt = 0;
  int                        value_errs = 0;
  int                        other_errs = 0;
  int                        rst_cycles = 0;
  int                        launch_cnt = 0;
  logic                      joined;
  logic                      rankable;

  bridge_to_outside bridge_to_outside_inst (.*);

  `include "bridge_tb_tasks.svh"

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // saturating count of edges since reset release
  always @(posedge clk) begin
    edge_cnt <= ext_rst_b ? 0 : ((edge_cnt < 1000) ? edge_cnt + 1 : edge_cnt);
    if (rst) rst_cycles <= rst_cycles + 1;
    if (next_state) launch_cnt <= launch_cnt + 1;
  end

  // join done five edges after release
  assign joined = (edge_cnt >= 5);
  // flag-only difference has no defined rank
  assign rankable = (ext_cpu_index[`BRIDGE_INDEX_ACTIVE_BIT-1:0] !=
                     own_idx[`BRIDGE_INDEX_ACTIVE_BIT-1:0]) || (ext_cpu_index == own_idx);

  idle_after_reset_chk: assert property (@(posedge clk) ext_rst_b |=> (!disp_online &&
    !ext_next_cpu_e && !next_state && !rst && !ext_rst_e && !ext_dispatcher_q &&
    ext_cpu_msg == msg_none && ind_rel == rel_none))
    else note_mismatch("outputs active after reset");
  // core reset, bus busy and join strobe together on the fourth edge after release
  rst_pulse_chk: assert property (@(posedge clk) disable iff (ext_rst_b)
    (rst || ext_rst_e || bus_busy_out) |->
    (rst && ext_rst_e && bus_busy_out && edge_cnt == 4))
    else note_mismatch("core reset, join strobe or bus busy misplaced");
  rst_width_chk: assert property (@(posedge clk) disable iff (ext_rst_b)
    rst |=> (!rst && !ext_rst_e))
    else note_mismatch("core reset longer than one cycle");
  launch_chk: assert property (@(posedge clk) disable iff (ext_rst_b)
    (joined && !bus_busy_in && !ext_next_cpu_e && ext_next_cpu_q && ext_cpu_index == own_idx &&
     state == wait_for_start) |=> (disp_online && next_state && ext_next_cpu_e &&
     ext_cpu_msg == msg_start && base_addr == $past(addr_in) + HDR &&
     base_addr_data == (($past(data_in) == '0) ? $past(addr_in) : $past(data_in)) + HDR))
    else note_mismatch("launch outputs or addresses wrong");
  read_gate_chk: assert property (@(posedge clk) disable iff (ext_rst_b)
    ext_read_q == ((disp_online && read_class(state)) ? read_q : 1'b0))
    else note_mismatch("outside read request gated wrongly");
  write_gate_chk: assert property (@(posedge clk) disable iff (ext_rst_b)
    ext_write_q == ((disp_online && write_class(state)) ? write_q : 1'b0))
    else note_mismatch("outside write request gated wrongly");
  // dispatcher request follows the state class of the edge before
  dispatcher_chk: assert property (@(posedge clk) disable iff (ext_rst_b)
    (joined && !bus_busy_in) |=>
    ext_dispatcher_q == (read_class($past(state)) || write_class($past(state))))
    else note_mismatch("dispatcher request does not follow the state class");
  fork_out_chk: assert property (@(posedge clk) disable iff (ext_rst_b)
    (int_cpu_msg_in == msg_fork_thrd || int_cpu_msg_in == msg_stop_thrd) |->
    ext_cpu_msg == int_cpu_msg_in)
    else note_mismatch("fork or stop not forwarded out");
  done_in_chk: assert property (@(posedge clk) disable iff (ext_rst_b)
    int_cpu_msg_out == ((ext_cpu_msg_in == msg_fork_done || ext_cpu_msg_in == msg_stop_done) ?
    ext_cpu_msg_in : msg_none))
    else note_mismatch("incoming message filtered wrongly");
  rank_chk: assert property (@(posedge clk) disable iff (ext_rst_b)
    (joined && !rst && ext_next_cpu_q && rankable) |=>
    ind_rel == expected_rank($past(ext_cpu_index), own_idx))
    else note_mismatch("index relation wrong");
  // busy bus freezes the token state
  stall_chk: assert property (@(posedge clk) disable iff (ext_rst_b)
    (joined && bus_busy_in && ext_next_cpu_q) |=> (disp_online == $past(disp_online) &&
    ext_next_cpu_e == $past(ext_next_cpu_e)))
    else note_mismatch("token state moved under busy bus");

  initial begin
    void'($urandom(32'h44a));
    // flag set and magnitude kept clear of both ends
    own_idx        = {1'b1, 2'b01, 29'($urandom)};
    ext_rst_b      = 1'b1;
    state          = wait_for_start;
    read_q         = 1'b0;
    write_q        = 1'b0;
    addr_in        = '0;
    data_in        = '0;
    bus_busy_in    = 1'b0;
    ext_next_cpu_q = 1'b0;
    ext_cpu_index  = own_idx;
    int_cpu_msg_in = msg_none;
    ext_cpu_msg_in = msg_none;
    apply_reset();
    run_launch(1'b0);
    run_launch(1'b1);
    gate_request(read_src0, 1'b1, 1'b1);
    gate_request(write_cond, 1'b1, 1'b1);
    gate_request(other, 1'b1, 1'b0);
    gate_request(read_dst_p, 1'b0, 1'b1);
    idle_requests(20);
    sweep_messages();
    rank_offers(12);
    stall_token();
    repeat (4) @(posedge clk);
    rst_count_chk: assert (rst_cycles == 1)
      else note_mismatch($sformatf("core reset high for %0d cycles", rst_cycles));
    launch_count_chk: assert (launch_cnt == 2)
      else note_mismatch($sformatf("%0d thread launches instead of two", launch_cnt));
    $display("errors: value %0d, other %0d", value_errs, other_errs);
    if (value_errs + other_errs == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // run limit
  initial begin
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_cnt++;
    end
    other_errs++;
    $display("run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("errors: value %0d, other %0d", value_errs, other_errs);
    $display("Test FAILED");
    $finish;
  end

endmodule

/* bridge_to_outside.f */
+incdir+rtl
+incdir+test
rtl/bridge_state_pkg.sv
rtl/bridge_msg_pkg.sv
rtl/state_class_decoder.sv
rtl/reset_sequencer.sv
rtl/token_controller.sv
rtl/message_router.sv
rtl/index_comparator.sv
rtl/bridge_to_outside.sv
test/tb_bridge_to_outside.sv
